// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := mem_test_tb
FILELIST  := all.f
PASS_MSG  := Test OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: all.f
rtl/mem_test_pkg.sv
rtl/reset_gen.sv
rtl/pattern_gen.sv
rtl/stripe_router.sv
rtl/sram_port.sv
rtl/result_check.sv
rtl/mem_test_top.sv
tb/sram_model.sv
tb/mem_test_tb.sv

// File: rtl/mem_test_pkg.sv
package mem_test_pkg;

  localparam int NUM_S = 4;
  localparam int SRAM_ADDR_WIDTH = 18;
  localparam int SRAM_DATA_WIDTH = 16;
  localparam int WORD_ADDR_WIDTH = 20;

  // Test region is NUM_BURSTS * NUM_BEATS words
  localparam int NUM_BURSTS = 4;
  localparam int NUM_BEATS = 16;

  localparam int RST_CYCLES = 16;

  localparam logic [15:0] PATTERN_KEY = 16'ha5c3;

  typedef logic [WORD_ADDR_WIDTH-1:0] word_addr_t;
  typedef logic [SRAM_ADDR_WIDTH-1:0] sram_addr_t;
  typedef logic [SRAM_DATA_WIDTH-1:0] sram_data_t;
  typedef logic [1:0] chip_sel_t;
  typedef logic [7:0] pass_cnt_t;

  typedef enum logic [1:0] {
    IDLE,
    WRITE,
    READ,
    WAIT_DONE
  } seq_state_t;

  // Pass count in the upper byte, word address in the lower byte
  function automatic sram_data_t pattern_word(pass_cnt_t pass, word_addr_t addr);
    return {pass, addr[7:0]} ^ PATTERN_KEY;
  endfunction

endpackage

// File: rtl/mem_test_top.sv
`timescale 1ns/1ns

module mem_test_top (
  input  logic CLK,
  input  logic rst_n,
  output logic led1,
  output logic led2,

  output logic                                    l_sram_a_oe_n,
  output logic                                    l_sram_a_we_n,
  output mem_test_pkg::sram_addr_t                l_sram_a_addr,
  inout  wire [mem_test_pkg::SRAM_DATA_WIDTH-1:0] l_sram_a_data,

  output logic                                    l_sram_b_oe_n,
  output logic                                    l_sram_b_we_n,
  output mem_test_pkg::sram_addr_t                l_sram_b_addr,
  inout  wire [mem_test_pkg::SRAM_DATA_WIDTH-1:0] l_sram_b_data,

  output logic                                    r_sram_a_oe_n,
  output logic                                    r_sram_a_we_n,
  output mem_test_pkg::sram_addr_t                r_sram_a_addr,
  inout  wire [mem_test_pkg::SRAM_DATA_WIDTH-1:0] r_sram_a_data,

  output logic                                    r_sram_b_oe_n,
  output logic                                    r_sram_b_we_n,
  output mem_test_pkg::sram_addr_t                r_sram_b_addr,
  inout  wire [mem_test_pkg::SRAM_DATA_WIDTH-1:0] r_sram_b_data,

  output logic [7:0]              dbg_addr,
  output logic [7:0]              dbg_errors,
  output mem_test_pkg::pass_cnt_t dbg_pass
);

  logic                     int_rst_n;
  logic                     req;
  logic                     req_we;
  mem_test_pkg::word_addr_t req_addr;
  mem_test_pkg::sram_data_t req_wdata;
  logic                     req_last;
  mem_test_pkg::pass_cnt_t  req_pass;

  logic [mem_test_pkg::NUM_S-1:0] port_req;
  logic [mem_test_pkg::NUM_S-1:0] port_we;
  logic [mem_test_pkg::NUM_S-1:0] port_rvalid;
  mem_test_pkg::sram_addr_t       port_addr [mem_test_pkg::NUM_S];
  mem_test_pkg::sram_data_t       port_wdata[mem_test_pkg::NUM_S];
  mem_test_pkg::sram_data_t       port_rdata[mem_test_pkg::NUM_S];

  logic                     chk_valid;
  mem_test_pkg::sram_data_t chk_data;
  mem_test_pkg::word_addr_t chk_addr;
  logic                     chk_last;
  mem_test_pkg::pass_cnt_t  chk_pass;
  logic                     test_done;
  logic                     test_pass;
  logic [7:0]               done_cnt;

  reset_gen reset_gen_i (.CLK(CLK), .rst_n(rst_n), .int_rst_n(int_rst_n));

  pattern_gen pattern_gen_i (
    .CLK(CLK), .rst_n(int_rst_n), .req(req), .req_we(req_we), .req_addr(req_addr),
    .req_wdata(req_wdata), .req_last(req_last), .req_pass(req_pass), .test_done(test_done)
  );

  stripe_router stripe_router_i (
    .CLK(CLK), .rst_n(int_rst_n), .req(req), .req_we(req_we), .req_addr(req_addr),
    .req_wdata(req_wdata), .req_last(req_last), .req_pass(req_pass),
    .port_req(port_req), .port_we(port_we), .port_addr(port_addr),
    .port_wdata(port_wdata), .port_rdata(port_rdata), .port_rvalid(port_rvalid),
    .chk_valid(chk_valid), .chk_data(chk_data), .chk_addr(chk_addr),
    .chk_last(chk_last), .chk_pass(chk_pass)
  );

  // Chip index 0..3 is l_sram_a, l_sram_b, r_sram_a, r_sram_b
  sram_port sram_port_0 (
    .CLK(CLK), .rst_n(int_rst_n), .port_req(port_req[0]), .port_we(port_we[0]),
    .port_addr(port_addr[0]), .port_wdata(port_wdata[0]), .rdata(port_rdata[0]),
    .rvalid(port_rvalid[0]), .sram_oe_n(l_sram_a_oe_n), .sram_we_n(l_sram_a_we_n),
    .sram_addr(l_sram_a_addr), .sram_data(l_sram_a_data)
  );

  sram_port sram_port_1 (
    .CLK(CLK), .rst_n(int_rst_n), .port_req(port_req[1]), .port_we(port_we[1]),
    .port_addr(port_addr[1]), .port_wdata(port_wdata[1]), .rdata(port_rdata[1]),
    .rvalid(port_rvalid[1]), .sram_oe_n(l_sram_b_oe_n), .sram_we_n(l_sram_b_we_n),
    .sram_addr(l_sram_b_addr), .sram_data(l_sram_b_data)
  );

  sram_port sram_port_2 (
    .CLK(CLK), .rst_n(int_rst_n), .port_req(port_req[2]), .port_we(port_we[2]),
    .port_addr(port_addr[2]), .port_wdata(port_wdata[2]), .rdata(port_rdata[2]),
    .rvalid(port_rvalid[2]), .sram_oe_n(r_sram_a_oe_n), .sram_we_n(r_sram_a_we_n),
    .sram_addr(r_sram_a_addr), .sram_data(r_sram_a_data)
  );

  sram_port sram_port_3 (
    .CLK(CLK), .rst_n(int_rst_n), .port_req(port_req[3]), .port_we(port_we[3]),
    .port_addr(port_addr[3]), .port_wdata(port_wdata[3]), .rdata(port_rdata[3]),
    .rvalid(port_rvalid[3]), .sram_oe_n(r_sram_b_oe_n), .sram_we_n(r_sram_b_we_n),
    .sram_addr(r_sram_b_addr), .sram_data(r_sram_b_data)
  );

  result_check result_check_i (
    .CLK(CLK), .rst_n(int_rst_n), .chk_valid(chk_valid), .chk_data(chk_data),
    .chk_addr(chk_addr), .chk_last(chk_last), .chk_pass(chk_pass),
    .test_done(test_done), .test_pass(test_pass), .first_fail_addr(dbg_addr),
    .error_count(dbg_errors), .pass_count(dbg_pass)
  );

  always_ff @(posedge CLK) begin
    if (!int_rst_n) begin
      done_cnt <= '0;
    end else if (test_done) begin
      done_cnt <= done_cnt + 1'b1;
    end
  end

  // Slow blink from the pass count, fail light is sticky
  assign led1 = done_cnt[7];
  assign led2 = !test_pass;

endmodule

// File: rtl/pattern_gen.sv
`timescale 1ns/1ns

module pattern_gen (
  input  logic                     CLK,
  input  logic                     rst_n,
  output logic                     req,
  output logic                     req_we,
  output mem_test_pkg::word_addr_t req_addr,
  output mem_test_pkg::sram_data_t req_wdata,
  output logic                     req_last,
  output mem_test_pkg::pass_cnt_t  req_pass,
  input  logic                     test_done
);

  localparam int BEAT_W = $clog2(mem_test_pkg::NUM_BEATS);
  localparam int BURST_W = $clog2(mem_test_pkg::NUM_BURSTS);

  mem_test_pkg::seq_state_t state;
  mem_test_pkg::pass_cnt_t  pass;
  mem_test_pkg::word_addr_t addr;

  logic               phase;
  logic [ BEAT_W-1:0] beat;
  logic [BURST_W-1:0] burst;
  logic               last_beat;
  logic               last_burst;

  assign addr       = mem_test_pkg::word_addr_t'({burst, beat});
  assign last_beat  = beat == BEAT_W'(mem_test_pkg::NUM_BEATS - 1);
  assign last_burst = burst == BURST_W'(mem_test_pkg::NUM_BURSTS - 1);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state    <= mem_test_pkg::IDLE;
      pass     <= '0;
      phase    <= 1'b0;
      beat     <= '0;
      burst    <= '0;
      req      <= 1'b0;
      req_last <= 1'b0;
    end else begin
      req      <= 1'b0;
      req_last <= 1'b0;

      case (state)
        mem_test_pkg::IDLE: begin
          phase <= 1'b0;
          beat  <= '0;
          burst <= '0;
          state <= mem_test_pkg::WRITE;
        end

        mem_test_pkg::WRITE, mem_test_pkg::READ: begin
          phase <= !phase;
          // Request on even cycles only, one per port access time
          if (!phase) begin
            req      <= 1'b1;
            req_last <= (state == mem_test_pkg::READ) && last_beat && last_burst;
            if (last_beat) begin
              beat <= '0;
              if (last_burst) begin
                burst <= '0;
                state <= (state == mem_test_pkg::WRITE) ? mem_test_pkg::READ :
                                                          mem_test_pkg::WAIT_DONE;
              end else begin
                burst <= burst + 1'b1;
              end
            end else begin
              beat <= beat + 1'b1;
            end
          end
        end

        mem_test_pkg::WAIT_DONE: begin
          if (test_done) begin
            pass  <= pass + 1'b1;
            state <= mem_test_pkg::IDLE;
          end
        end

        default: state <= mem_test_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if ((state == mem_test_pkg::WRITE || state == mem_test_pkg::READ) && !phase) begin
      req_we    <= state == mem_test_pkg::WRITE;
      req_addr  <= addr;
      req_wdata <= mem_test_pkg::pattern_word(pass, addr);
      req_pass  <= pass;
    end
  end

endmodule

// File: rtl/reset_gen.sv
`timescale 1ns/1ns

module reset_gen (
  input  logic CLK,
  input  logic rst_n,
  output logic int_rst_n
);

  localparam int CNT_W = $clog2(mem_test_pkg::RST_CYCLES + 1);

  logic [CNT_W-1:0] cnt;

  // Count stops once the internal reset is released
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      cnt       <= '0;
      int_rst_n <= 1'b0;
    end else if (!int_rst_n) begin
      cnt <= cnt + 1'b1;
      if (cnt == CNT_W'(mem_test_pkg::RST_CYCLES - 1)) begin
        int_rst_n <= 1'b1;
      end
    end
  end

endmodule

// File: rtl/result_check.sv
`timescale 1ns/1ns

module result_check (
  input  logic                     CLK,
  input  logic                     rst_n,
  input  logic                     chk_valid,
  input  mem_test_pkg::sram_data_t chk_data,
  input  mem_test_pkg::word_addr_t chk_addr,
  input  logic                     chk_last,
  input  mem_test_pkg::pass_cnt_t  chk_pass,

  output logic                     test_done,
  output logic                     test_pass,
  output logic [7:0]               first_fail_addr,
  output logic [7:0]               error_count,
  output mem_test_pkg::pass_cnt_t  pass_count
);

  mem_test_pkg::sram_data_t expected;
  logic                     mismatch;

  assign expected = mem_test_pkg::pattern_word(chk_pass, chk_addr);
  assign mismatch = chk_valid && (chk_data != expected);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      test_done       <= 1'b0;
      test_pass       <= 1'b1;
      first_fail_addr <= '0;
      error_count     <= '0;
      pass_count      <= '0;
    end else begin
      test_done <= chk_valid && chk_last;

      if (chk_valid && chk_last) begin
        pass_count <= pass_count + 1'b1;
      end

      if (mismatch) begin
        test_pass <= 1'b0;
        // Sticky flag still set means this is the first failure
        if (test_pass) begin
          first_fail_addr <= chk_addr[7:0];
        end
        if (error_count != 8'hff) begin
          error_count <= error_count + 1'b1;
        end
      end
    end
  end

endmodule

// File: rtl/sram_port.sv
`timescale 1ns/1ns

module sram_port (
  input  logic                     CLK,
  input  logic                     rst_n,
  input  logic                     port_req,
  input  logic                     port_we,
  input  mem_test_pkg::sram_addr_t port_addr,
  input  mem_test_pkg::sram_data_t port_wdata,
  output mem_test_pkg::sram_data_t rdata,
  output logic                     rvalid,

  output logic                     sram_oe_n,
  output logic                     sram_we_n,
  output mem_test_pkg::sram_addr_t sram_addr,
  inout  wire [mem_test_pkg::SRAM_DATA_WIDTH-1:0] sram_data
);

  typedef enum logic [1:0] {
    P_IDLE,
    P_WRITE,
    P_READ
  } port_state_t;

  port_state_t              state;
  mem_test_pkg::sram_addr_t addr_q;
  mem_test_pkg::sram_data_t wdata_q;
  logic                     first;
  logic                     drive;

  // First phase runs straight off the registered request
  assign first     = (state == P_IDLE) && port_req;
  assign sram_addr = first ? port_addr : addr_q;
  assign sram_we_n = !(first && port_we);
  assign sram_oe_n = !((first && !port_we) || state == P_READ);

  // Data held one cycle past the we_n rising edge
  assign drive     = (first && port_we) || state == P_WRITE;
  assign sram_data = drive ? (first ? port_wdata : wdata_q) : 'z;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state  <= P_IDLE;
      rvalid <= 1'b0;
    end else begin
      rvalid <= state == P_READ;
      if (first) begin
        state <= port_we ? P_WRITE : P_READ;
      end else begin
        state <= P_IDLE;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (first) begin
      addr_q  <= port_addr;
      wdata_q <= port_wdata;
    end
    if (state == P_READ) begin
      rdata <= sram_data;
    end
  end

  assert property (@(posedge CLK) disable iff (!rst_n) sram_oe_n || sram_we_n)
    else $error("oe_n and we_n both low");

  assert property (@(posedge CLK) disable iff (!rst_n) (state != P_IDLE) |-> !port_req)
    else $error("request while port busy");

endmodule

// File: rtl/stripe_router.sv
`timescale 1ns/1ns

module stripe_router (
  input  logic                     CLK,
  input  logic                     rst_n,
  input  logic                     req,
  input  logic                     req_we,
  input  mem_test_pkg::word_addr_t req_addr,
  input  mem_test_pkg::sram_data_t req_wdata,
  input  logic                     req_last,
  input  mem_test_pkg::pass_cnt_t  req_pass,

  output logic [mem_test_pkg::NUM_S-1:0] port_req,
  output logic [mem_test_pkg::NUM_S-1:0] port_we,
  output mem_test_pkg::sram_addr_t       port_addr [mem_test_pkg::NUM_S],
  output mem_test_pkg::sram_data_t       port_wdata[mem_test_pkg::NUM_S],
  input  mem_test_pkg::sram_data_t       port_rdata[mem_test_pkg::NUM_S],
  input  logic [mem_test_pkg::NUM_S-1:0] port_rvalid,

  output logic                     chk_valid,
  output mem_test_pkg::sram_data_t chk_data,
  output mem_test_pkg::word_addr_t chk_addr,
  output logic                     chk_last,
  output mem_test_pkg::pass_cnt_t  chk_pass
);

  localparam int SEL_W = $bits(mem_test_pkg::chip_sel_t);

  mem_test_pkg::chip_sel_t sel;
  mem_test_pkg::chip_sel_t ret_sel;

  // One outstanding access per chip, so one tag per chip
  mem_test_pkg::word_addr_t tag_addr[mem_test_pkg::NUM_S];
  mem_test_pkg::pass_cnt_t  tag_pass[mem_test_pkg::NUM_S];
  logic                     tag_last[mem_test_pkg::NUM_S];

  assign sel = req_addr[SEL_W-1:0];

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      port_req <= '0;
    end else begin
      for (int i = 0; i < mem_test_pkg::NUM_S; i++) begin
        port_req[i] <= req && (sel == mem_test_pkg::chip_sel_t'(i));
      end
    end
  end

  always_ff @(posedge CLK) begin
    for (int i = 0; i < mem_test_pkg::NUM_S; i++) begin
      if (req && (sel == mem_test_pkg::chip_sel_t'(i))) begin
        port_we[i]    <= req_we;
        port_addr[i]  <= req_addr[mem_test_pkg::WORD_ADDR_WIDTH-1:SEL_W];
        port_wdata[i] <= req_wdata;
        tag_addr[i]   <= req_addr;
        tag_pass[i]   <= req_pass;
        tag_last[i]   <= req_last;
      end
    end
  end

  always_comb begin
    ret_sel = '0;
    for (int i = 0; i < mem_test_pkg::NUM_S; i++) begin
      if (port_rvalid[i]) begin
        ret_sel = mem_test_pkg::chip_sel_t'(i);
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      chk_valid <= 1'b0;
    end else begin
      chk_valid <= |port_rvalid;
    end
  end

  always_ff @(posedge CLK) begin
    chk_data <= port_rdata[ret_sel];
    chk_addr <= tag_addr[ret_sel];
    chk_pass <= tag_pass[ret_sel];
    chk_last <= tag_last[ret_sel];
  end

  // Request spacing must keep chip returns from overlapping
  assert property (@(posedge CLK) disable iff (!rst_n) $onehot0(port_rvalid))
    else $error("more than one port returned read data");

endmodule

// File: tb/mem_test_tb.sv
`timescale 1ns/1ns

module mem_test_tb;

  localparam int REGION       = mem_test_pkg::NUM_BURSTS * mem_test_pkg::NUM_BEATS;
  localparam int PASS_TIMEOUT = 2000;
  localparam int LONG_PASSES  = 128;
  localparam int TRIALS       = 4;
  localparam logic [31:0] LFSR_TAPS = 32'ha3000000;

  logic                     CLK;
  logic                     rst_n;
  logic                     led1;
  logic                     led2;
  logic [3:0]               oe_n;
  logic [3:0]               we_n;
  mem_test_pkg::sram_addr_t sram_addr [4];
  wire  [15:0]              data_0;
  wire  [15:0]              data_1;
  wire  [15:0]              data_2;
  wire  [15:0]              data_3;
  logic [7:0]               dbg_addr;
  logic [7:0]               dbg_errors;
  logic [7:0]               dbg_pass;

  logic                     fault_en;
  logic [1:0]               fault_chip;
  mem_test_pkg::sram_addr_t fault_ca;
  logic [3:0]               fault_bit;
  logic                     fault_val;

  logic [31:0] lfsr;
  int          errors;
  logic        timed_out;

  mem_test_top mem_test_top_i (
    .CLK(CLK), .rst_n(rst_n), .led1(led1), .led2(led2),
    .l_sram_a_oe_n(oe_n[0]), .l_sram_a_we_n(we_n[0]), .l_sram_a_addr(sram_addr[0]),
    .l_sram_a_data(data_0),
    .l_sram_b_oe_n(oe_n[1]), .l_sram_b_we_n(we_n[1]), .l_sram_b_addr(sram_addr[1]),
    .l_sram_b_data(data_1),
    .r_sram_a_oe_n(oe_n[2]), .r_sram_a_we_n(we_n[2]), .r_sram_a_addr(sram_addr[2]),
    .r_sram_a_data(data_2),
    .r_sram_b_oe_n(oe_n[3]), .r_sram_b_we_n(we_n[3]), .r_sram_b_addr(sram_addr[3]),
    .r_sram_b_data(data_3),
    .dbg_addr(dbg_addr), .dbg_errors(dbg_errors), .dbg_pass(dbg_pass)
  );

  sram_model sram_0 (
    .oe_n(oe_n[0]), .we_n(we_n[0]), .addr(sram_addr[0]), .data(data_0),
    .stuck_en(fault_en && fault_chip == 2'd0), .stuck_addr(fault_ca),
    .stuck_bit(fault_bit), .stuck_val(fault_val)
  );

  sram_model sram_1 (
    .oe_n(oe_n[1]), .we_n(we_n[1]), .addr(sram_addr[1]), .data(data_1),
    .stuck_en(fault_en && fault_chip == 2'd1), .stuck_addr(fault_ca),
    .stuck_bit(fault_bit), .stuck_val(fault_val)
  );

  sram_model sram_2 (
    .oe_n(oe_n[2]), .we_n(we_n[2]), .addr(sram_addr[2]), .data(data_2),
    .stuck_en(fault_en && fault_chip == 2'd2), .stuck_addr(fault_ca),
    .stuck_bit(fault_bit), .stuck_val(fault_val)
  );

  sram_model sram_3 (
    .oe_n(oe_n[3]), .we_n(we_n[3]), .addr(sram_addr[3]), .data(data_3),
    .stuck_en(fault_en && fault_chip == 2'd3), .stuck_addr(fault_ca),
    .stuck_bit(fault_bit), .stuck_val(fault_val)
  );

  always #5 CLK = !CLK;

  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsr[0]);
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // Pass in the upper byte, word address in the lower byte, then the key
  function automatic logic [15:0] expected_word(int pass, int addr);
    logic [15:0] w;
    w = {pass[7:0], addr[7:0]};
    return w ^ mem_test_pkg::PATTERN_KEY;
  endfunction

  function automatic int first_fail_pass(int addr, int bit_idx, logic val);
    logic [15:0] w;
    for (int p = 0; p < 256; p++) begin
      w = expected_word(p, addr);
      if (w[bit_idx] != val) begin
        return p;
      end
    end
    return -1;
  endfunction

  // One read of the stuck word per pass
  function automatic int errors_through(int last_pass, int addr, int bit_idx, logic val);
    logic [15:0] w;
    int          n;
    n = 0;
    for (int p = 0; p <= last_pass; p++) begin
      w = expected_word(p, addr);
      if (w[bit_idx] != val && n < 255) begin
        n++;
      end
    end
    return n;
  endfunction

  function automatic logic [15:0] model_word(int chip, int ca);
    case (chip)
      0: return sram_0.mem[ca];
      1: return sram_1.mem[ca];
      2: return sram_2.mem[ca];
      default: return sram_3.mem[ca];
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("ERROR %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_memory(input int pass);
    for (int a = 0; a < REGION; a++) begin
      check_value($sformatf("sram_%0d word %0d", a % 4, a / 4), model_word(a % 4, a / 4),
                  expected_word(pass, a));
    end
  endtask

  task automatic reset_dut();
    @(posedge CLK);
    rst_n <= 1'b0;
    repeat (3) @(posedge CLK);
    rst_n <= 1'b1;
    // Pins idle through the reset stretch
    repeat (mem_test_pkg::RST_CYCLES) begin
      @(negedge CLK);
      check_value("we_n/oe_n", {we_n, oe_n}, 8'hff);
      check_value("led2", led2, 0);
    end
    check_value("led1", led1, 0);
    check_value("dbg_pass", dbg_pass, 0);
    check_value("dbg_errors", dbg_errors, 0);
    check_value("dbg_addr", dbg_addr, 0);
  endtask

  task automatic wait_pass(input int target);
    for (int i = 0; i < PASS_TIMEOUT; i++) begin
      @(negedge CLK);
      if (dbg_pass == 8'(target)) begin
        // Done counter steps one cycle after the pass count
        @(negedge CLK);
        return;
      end
    end
    timed_out = 1'b1;
    errors++;
    $display("Timed out waiting for pass %0d to complete", target);
  endtask

  task automatic run_tests();
    int chip;
    int ca;
    int bit_idx;
    int val;
    int waddr;
    int fail_pass;
    int passes;
    logic exp_fail;

    // Fault-free run, long enough for the pass LED
    reset_dut();
    for (int p = 0; p < LONG_PASSES; p++) begin
      wait_pass(p + 1);
      if (timed_out) begin
        return;
      end
      check_value("dbg_errors", dbg_errors, 0);
      check_value("led2", led2, 0);
      check_value("led1", led1, ((p + 1) >> 7) & 1);
      check_memory(p);
    end

    for (int t = 0; t < TRIALS; t++) begin
      take_bits(2, chip);
      take_bits(4, ca);
      take_bits(4, bit_idx);
      take_bits(1, val);
      waddr     = ca * 4 + chip;
      fail_pass = first_fail_pass(waddr, bit_idx, val);
      $display("Trial %0d: chip %0d word %0d bit %0d stuck at %0d, first failing pass %0d",
               t, chip, waddr, bit_idx, val, fail_pass);

      @(posedge CLK);
      fault_en   <= 1'b1;
      fault_chip <= chip[1:0];
      fault_ca   <= mem_test_pkg::sram_addr_t'(ca);
      fault_bit  <= bit_idx[3:0];
      fault_val  <= val[0];
      reset_dut();

      // A bit that never mismatches still runs two clean passes
      passes = (fail_pass < 0) ? 2 : fail_pass + 2;
      for (int p = 0; p < passes; p++) begin
        wait_pass(p + 1);
        if (timed_out) begin
          return;
        end
        exp_fail = fail_pass >= 0 && p >= fail_pass;
        check_value("led2", led2, exp_fail);
        check_value("dbg_errors", dbg_errors, errors_through(p, waddr, bit_idx, val[0]));
        check_value("dbg_addr", dbg_addr, exp_fail ? waddr[7:0] : 8'h00);
      end
    end

    @(posedge CLK);
    fault_en <= 1'b0;
    reset_dut();
  endtask

  initial begin
    CLK        = 1'b0;
    rst_n      = 1'b0;
    fault_en   = 1'b0;
    fault_chip = '0;
    fault_ca   = '0;
    fault_bit  = '0;
    fault_val  = 1'b0;
    lfsr       = 32'h703b68a0;
    errors     = 0;
    timed_out  = 1'b0;

    run_tests();

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: tb/sram_model.sv
`timescale 1ns/1ns

module sram_model (
  input  logic                                    oe_n,
  input  logic                                    we_n,
  input  mem_test_pkg::sram_addr_t                addr,
  inout  wire [mem_test_pkg::SRAM_DATA_WIDTH-1:0] data,

  input  logic                                    stuck_en,
  input  mem_test_pkg::sram_addr_t                stuck_addr,
  input  logic [3:0]                              stuck_bit,
  input  logic                                    stuck_val
);

  mem_test_pkg::sram_data_t mem [2**mem_test_pkg::SRAM_ADDR_WIDTH];
  mem_test_pkg::sram_data_t rd;

  // Chip latches the word as we_n rises
  always @(posedge we_n) begin
    mem[addr] <= data;
  end

  // Stuck bit shows only on the read path
  always_comb begin
    rd = mem[addr];
    if (stuck_en && addr == stuck_addr) begin
      rd[stuck_bit] = stuck_val;
    end
  end

  assign data = (!oe_n && we_n) ? rd : 'z;

endmodule
